/* source/execute_macros.svh */
`ifndef EXECUTE_MACROS_SVH
`define EXECUTE_MACROS_SVH

`define DATA_W 16

// alu operation codes
`define ALU_ADD 3'd0
`define ALU_OR  3'd1
`define ALU_XOR 3'd2
`define ALU_AND 3'd3
`define ALU_RLL 3'd4
`define ALU_SLL 3'd5
`define ALU_ROR 3'd6
`define ALU_SRL 3'd7

// branch conditions on the tested register
`define BR_NONE 3'd0
`define BR_EQZ  3'd1
`define BR_NEZ  3'd2
`define BR_LTZ  3'd3
`define BR_GEZ  3'd4

`define SET_EQ 2'd0
`define SET_LT 2'd1
`define SET_LE 2'd2
`define SET_CO 2'd3

// xx bypass select, code 2 gives zero
`define XX_SPEC  2'd0
`define XX_PCINC 2'd1
`define XX_ALU   2'd3

// mw bypass select
`define XM_SPEC  2'd0
`define XM_PCINC 2'd1
`define XM_MEM   2'd2
`define XM_ALU   2'd3

`endif

/* source/execute_pkg.sv */
`include "execute_macros.svh"

package execute_pkg;

  typedef struct packed {
    logic [2:0] aluOp;
    logic       invA;
    logic       invB;
    logic       cin;
  } aluCtrl_t;

  // change of flow controls from decode
  typedef struct packed {
    logic       immSrc;
    logic       aluJump;
    logic       jump;
    logic [2:0] brControl;
  } flowCtrl_t;

  typedef struct packed {
    logic       setIf;
    logic [1:0] setControl;
    logic       btr;
    logic       lbi;
    logic       stu;
  } specCtrl_t;

  // forwarding enables and source selects from hazard logic
  typedef struct packed {
    logic       fwdXxA;
    logic       fwdXxB;
    logic       fwdXmA;
    logic       fwdXmB;
    logic [1:0] xxSel;
    logic [1:0] xmSel;
  } fwdCtrl_t;

  typedef struct packed {
    logic [`DATA_W-1:0] specOps;
    logic [`DATA_W-1:0] pcInc;
    logic [`DATA_W-1:0] aluOut;
  } xmBypass_t;

  typedef struct packed {
    logic [`DATA_W-1:0] specOps;
    logic [`DATA_W-1:0] pcInc;
    logic [`DATA_W-1:0] readMemData;
    logic [`DATA_W-1:0] aluOut;
  } mwBypass_t;

  // sf is the signed less-than, result sign xor overflow
  typedef struct packed {
    logic zf;
    logic sf;
    logic of;
    logic cf;
  } aluFlags_t;

  // immediates arrive already sign or zero extended
  typedef struct packed {
    logic [`DATA_W-1:0] pc;
    logic [`DATA_W-1:0] aluA;
    logic [`DATA_W-1:0] aluB;
    logic [`DATA_W-1:0] read2Data;
    logic [`DATA_W-1:0] imm11;
    logic [`DATA_W-1:0] imm8;
  } exOperands_t;

  typedef struct packed {
    logic        valid;
    logic        halt;
    exOperands_t ops;
    aluCtrl_t    aluCtrl;
    flowCtrl_t   flowCtrl;
    specCtrl_t   specCtrl;
    fwdCtrl_t    fwdCtrl;
  } exIn_t;

  typedef struct packed {
    logic               valid;
    logic               halt;
    logic [`DATA_W-1:0] nextPc;
    logic [`DATA_W-1:0] aluOut;
    logic [`DATA_W-1:0] outData;
    logic [`DATA_W-1:0] specOps;
    logic               flush;
  } xmReg_t;

endpackage

/* source/forward_unit.sv */
`include "execute_macros.svh"

module forward_unit (
  input  execute_pkg::exOperands_t ops,
  input  execute_pkg::fwdCtrl_t    fwd,
  input  logic                     stu,
  input  execute_pkg::xmBypass_t   xm,
  input  execute_pkg::mwBypass_t   mw,
  output logic [`DATA_W-1:0]       finalA,
  output logic [`DATA_W-1:0]       finalB,
  output logic [`DATA_W-1:0]       finalStore
);

  logic [`DATA_W-1:0] xxVal;
  logic [`DATA_W-1:0] mwVal;
  logic [`DATA_W-1:0] mwA;
  logic [`DATA_W-1:0] mwB;
  logic [`DATA_W-1:0] mwStore;

  // value taken from the xm register, code 2 has no source
  always_comb begin
    case (fwd.xxSel)
      `XX_SPEC:  xxVal = xm.specOps;
      `XX_PCINC: xxVal = xm.pcInc;
      `XX_ALU:   xxVal = xm.aluOut;
      default:   xxVal = '0;
    endcase
  end

  always_comb begin
    case (fwd.xmSel)
      `XM_SPEC:  mwVal = mw.specOps;
      `XM_PCINC: mwVal = mw.pcInc;
      `XM_MEM:   mwVal = mw.readMemData;
      default:   mwVal = mw.aluOut;
    endcase
  end

  // mw forward first, then the younger xx forward overrides it
  assign mwA    = fwd.fwdXmA ? mwVal : ops.aluA;
  assign finalA = fwd.fwdXxA ? xxVal : mwA;

  // stu puts the immediate on B, so B keeps aluB
  assign mwB    = (fwd.fwdXmB && !stu) ? mwVal : ops.aluB;
  assign finalB = (fwd.fwdXxB && !stu) ? xxVal : mwB;

  assign mwStore    = fwd.fwdXmB ? mwVal : ops.read2Data;
  assign finalStore = fwd.fwdXxB ? xxVal : mwStore;

  always_comb begin
    assert (!((fwd.fwdXxA || fwd.fwdXxB) && fwd.xxSel == 2'd2))
      else $error("xx forward active with empty select code");
  end

endmodule

/* source/alu.sv */
`include "execute_macros.svh"

module alu (
  input  logic [`DATA_W-1:0]   inA,
  input  logic [`DATA_W-1:0]   inB,
  input  execute_pkg::aluCtrl_t ctrl,
  output logic [`DATA_W-1:0]   result,
  output execute_pkg::aluFlags_t flags
);

  logic [`DATA_W-1:0]   opA;
  logic [`DATA_W-1:0]   opB;
  logic [`DATA_W:0]     sum;
  logic [3:0]           shAmt;
  logic [2*`DATA_W-1:0] rotLeft;
  logic [2*`DATA_W-1:0] rotRight;
  logic                 overflow;

  // inversion applies to every operation, so andn comes from and with invB
  assign opA = ctrl.invA ? ~inA : inA;
  assign opB = ctrl.invB ? ~inB : inB;

  // 17 bit sum keeps the carry out
  assign sum = {1'b0, opA} + {1'b0, opB} + {{`DATA_W{1'b0}}, ctrl.cin};

  assign shAmt = opB[3:0];

  // rotate through a doubled copy of the operand
  assign rotLeft  = {opA, opA} << shAmt;
  assign rotRight = {opA, opA} >> shAmt;

  // signed overflow when both addends agree in sign and the sum does not
  assign overflow = (opA[`DATA_W-1] == opB[`DATA_W-1]) &&
                    (sum[`DATA_W-1] != opA[`DATA_W-1]);

  always_comb begin
    case (ctrl.aluOp)
      `ALU_ADD: result = sum[`DATA_W-1:0];
      `ALU_OR:  result = opA | opB;
      `ALU_XOR: result = opA ^ opB;
      `ALU_AND: result = opA & opB;
      `ALU_RLL: result = rotLeft[2*`DATA_W-1:`DATA_W];
      `ALU_SLL: result = opA << shAmt;
      `ALU_ROR: result = rotRight[`DATA_W-1:0];
      `ALU_SRL: result = opA >> shAmt;
      default:  result = sum[`DATA_W-1:0];
    endcase
  end

  // zf follows the selected result, the rest come from the adder
  assign flags.zf = (result == '0);
  assign flags.sf = sum[`DATA_W-1] ^ overflow;
  assign flags.of = overflow;
  assign flags.cf = sum[`DATA_W];

endmodule

/* source/special_ops.sv */
`include "execute_macros.svh"

module special_ops (
  input  logic [`DATA_W-1:0]     opA,
  input  logic [`DATA_W-1:0]     imm8,
  input  execute_pkg::specCtrl_t  ctrl,
  input  execute_pkg::aluFlags_t  flags,
  output logic [`DATA_W-1:0]     specOps
);

  logic               setBit;
  logic [`DATA_W-1:0] reversed;
  logic [`DATA_W-1:0] slbi;

  // condition picked by the set code, flags come from a subtract
  always_comb begin
    case (ctrl.setControl)
      `SET_EQ: setBit = flags.zf;
      `SET_LT: setBit = flags.sf;
      `SET_LE: setBit = flags.sf | flags.zf;
      default: setBit = flags.cf;
    endcase
  end

  always_comb begin
    for (int i = 0; i < `DATA_W; i++) begin
      reversed[i] = opA[`DATA_W-1-i];
    end
  end

  // shift and load byte, old low byte moves up
  assign slbi = {opA[7:0], imm8[7:0]};

  always_comb begin
    if (ctrl.setIf) begin
      specOps = {{(`DATA_W-1){1'b0}}, setBit};
    end else if (ctrl.lbi) begin
      specOps = imm8;
    end else if (ctrl.btr) begin
      specOps = reversed;
    end else begin
      specOps = slbi;
    end
  end

endmodule

/* source/execute.sv */
`include "execute_macros.svh"

module execute (
  input  execute_pkg::exIn_t      exIn,
  input  execute_pkg::xmBypass_t  xm,
  input  execute_pkg::mwBypass_t  mw,
  output execute_pkg::xmReg_t     result
);

  import execute_pkg::*;

  logic [`DATA_W-1:0] finalA;
  logic [`DATA_W-1:0] finalB;
  logic [`DATA_W-1:0] finalStore;
  logic [`DATA_W-1:0] aluOut;
  logic [`DATA_W-1:0] specOps;
  logic [`DATA_W-1:0] jumpOffset;
  logic [`DATA_W-1:0] jumpTarget;
  aluFlags_t          aluFlags;
  aluCtrl_t           pcCtrl;
  logic               brSel;
  logic               takeFlow;

  forward_unit fwdUnit (
    .ops        (exIn.ops),
    .fwd        (exIn.fwdCtrl),
    .stu        (exIn.specCtrl.stu),
    .xm         (xm),
    .mw         (mw),
    .finalA     (finalA),
    .finalB     (finalB),
    .finalStore (finalStore)
  );

  alu mainAlu (
    .inA    (finalA),
    .inB    (finalB),
    .ctrl   (exIn.aluCtrl),
    .result (aluOut),
    .flags  (aluFlags)
  );

  special_ops specUnit (
    .opA     (finalA),
    .imm8    (exIn.ops.imm8),
    .ctrl    (exIn.specCtrl),
    .flags   (aluFlags),
    .specOps (specOps)
  );

  // second alu as a plain adder for pc relative targets
  assign pcCtrl     = '{aluOp: `ALU_ADD, invA: 1'b0, invB: 1'b0, cin: 1'b0};
  assign jumpOffset = exIn.flowCtrl.immSrc ? exIn.ops.imm8 : exIn.ops.imm11;

  alu pcAdder (
    .inA    (exIn.ops.pc),
    .inB    (jumpOffset),
    .ctrl   (pcCtrl),
    .result (jumpTarget),
    .flags  ()
  );

  // the alu passes the tested register through, so its flags describe it
  always_comb begin
    case (exIn.flowCtrl.brControl)
      `BR_EQZ: brSel = aluFlags.zf;
      `BR_NEZ: brSel = ~aluFlags.zf;
      `BR_LTZ: brSel = aluFlags.sf;
      `BR_GEZ: brSel = ~aluFlags.sf;
      default: brSel = 1'b0;
    endcase
  end

  assign takeFlow = brSel | exIn.flowCtrl.jump;

  always_comb begin
    result.valid   = exIn.valid;
    result.halt    = exIn.halt;
    result.aluOut  = aluOut;
    result.specOps = specOps;
    // register jumps win over relative targets
    if (exIn.flowCtrl.aluJump) begin
      result.nextPc = aluOut;
    end else if (takeFlow) begin
      result.nextPc = jumpTarget;
    end else begin
      result.nextPc = exIn.ops.pc;
    end
    result.outData = exIn.specCtrl.stu ? finalStore : finalB;
    // only a real instruction can redirect fetch
    result.flush   = exIn.valid & (exIn.flowCtrl.aluJump | takeFlow);
  end

endmodule

/* source/execute_stage.sv */
`include "execute_macros.svh"

module execute_stage (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic                    stall,
  input  execute_pkg::exIn_t      exIn,
  input  execute_pkg::xmBypass_t  xmBypass,
  input  execute_pkg::mwBypass_t  mwBypass,
  output execute_pkg::xmReg_t     xmOut
);

  import execute_pkg::*;

  xmReg_t nextXm;

  execute datapath (
    .exIn   (exIn),
    .xm     (xmBypass),
    .mw     (mwBypass),
    .result (nextXm)
  );

  // xm register, payload fields only load and have no reset
  always_ff @(posedge clk) begin
    if (!rstN) begin
      xmOut.valid <= 1'b0;
      xmOut.halt  <= 1'b0;
      xmOut.flush <= 1'b0;
    end else if (!stall) begin
      xmOut.valid   <= nextXm.valid;
      // a bubble must not carry a halt down the pipe
      xmOut.halt    <= nextXm.valid & nextXm.halt;
      xmOut.flush   <= nextXm.flush;
      xmOut.nextPc  <= nextXm.nextPc;
      xmOut.aluOut  <= nextXm.aluOut;
      xmOut.outData <= nextXm.outData;
      xmOut.specOps <= nextXm.specOps;
    end
  end

  stallHold: assert property (@(posedge clk) disable iff (!rstN) stall |=> $stable(xmOut));

  flushValid: assert property (@(posedge clk) disable iff (!rstN) xmOut.flush |-> xmOut.valid);

endmodule

/* test/execute_model.svh */
`ifndef EXECUTE_MODEL_SVH
`define EXECUTE_MODEL_SVH

`include "execute_macros.svh"

function automatic logic [`DATA_W-1:0] aluResult(input logic [`DATA_W-1:0] a,
                                                 input logic [`DATA_W-1:0] b,
                                                 input aluCtrl_t c);
  logic [`DATA_W-1:0] x;
  logic [`DATA_W-1:0] y;
  int                 n;
  int                 i;
  x = c.invA ? ~a : a;
  y = c.invB ? ~b : b;
  n = {28'b0, y[3:0]};
  if (c.aluOp == `ALU_OR) return x | y;
  if (c.aluOp == `ALU_XOR) return x ^ y;
  if (c.aluOp == `ALU_AND) return x & y;
  if (c.aluOp == `ALU_SLL) return x << n;
  if (c.aluOp == `ALU_SRL) return x >> n;
  // rotates one bit position at a time
  if (c.aluOp == `ALU_RLL || c.aluOp == `ALU_ROR) begin
    for (i = 0; i < n; i++) begin
      if (c.aluOp == `ALU_RLL) x = {x[`DATA_W-2:0], x[`DATA_W-1]};
      else x = {x[0], x[`DATA_W-1:1]};
    end
    return x;
  end
  return x + y + {{(`DATA_W-1){1'b0}}, c.cin};
endfunction

// sf is the sign of the exact signed sum, taken from an 18 bit total
function automatic aluFlags_t aluStatus(input logic [`DATA_W-1:0] a, input logic [`DATA_W-1:0] b,
                                        input aluCtrl_t c, input logic [`DATA_W-1:0] res);
  logic [`DATA_W-1:0] x;
  logic [`DATA_W-1:0] y;
  logic [`DATA_W+1:0] exact;
  logic [`DATA_W:0]   wide;
  aluFlags_t          f;
  x = c.invA ? ~a : a;
  y = c.invB ? ~b : b;
  exact = {{2{x[`DATA_W-1]}}, x} + {{2{y[`DATA_W-1]}}, y} + {{(`DATA_W+1){1'b0}}, c.cin};
  wide = {1'b0, x} + {1'b0, y} + {{`DATA_W{1'b0}}, c.cin};
  f.zf = (res == '0);
  f.sf = exact[`DATA_W+1];
  f.of = exact[`DATA_W] ^ exact[`DATA_W-1];
  f.cf = wide[`DATA_W];
  return f;
endfunction

function automatic logic [`DATA_W-1:0] specialResult(input logic [`DATA_W-1:0] a,
                                                     input logic [`DATA_W-1:0] imm8,
                                                     input specCtrl_t s, input aluFlags_t f);
  logic [`DATA_W-1:0] r;
  logic               cond;
  int                 i;
  if (s.setIf) begin
    if (s.setControl == `SET_EQ) cond = f.zf;
    else if (s.setControl == `SET_LT) cond = f.sf;
    else if (s.setControl == `SET_LE) cond = f.sf | f.zf;
    else cond = f.cf;
    return {{(`DATA_W-1){1'b0}}, cond};
  end
  if (s.lbi) return imm8;
  if (s.btr) begin
    for (i = 0; i < `DATA_W; i++) begin
      r[`DATA_W-1-i] = a[i];
    end
    return r;
  end
  return {a[7:0], imm8[7:0]};
endfunction

function automatic xmReg_t expectedXm(input exIn_t in, input xmBypass_t xm, input mwBypass_t mw);
  fwdCtrl_t           fw;
  logic [`DATA_W-1:0] xxVal;
  logic [`DATA_W-1:0] mwVal;
  logic [`DATA_W-1:0] a;
  logic [`DATA_W-1:0] b;
  logic [`DATA_W-1:0] store;
  logic [`DATA_W-1:0] offset;
  aluFlags_t          f;
  logic               brSel;
  xmReg_t             r;
  fw = in.fwdCtrl;
  if (fw.xxSel == `XX_SPEC) xxVal = xm.specOps;
  else if (fw.xxSel == `XX_PCINC) xxVal = xm.pcInc;
  else if (fw.xxSel == `XX_ALU) xxVal = xm.aluOut;
  else xxVal = '0;
  if (fw.xmSel == `XM_SPEC) mwVal = mw.specOps;
  else if (fw.xmSel == `XM_PCINC) mwVal = mw.pcInc;
  else if (fw.xmSel == `XM_MEM) mwVal = mw.readMemData;
  else mwVal = mw.aluOut;
  // the xx forward is younger and wins over mw
  a = fw.fwdXxA ? xxVal : (fw.fwdXmA ? mwVal : in.ops.aluA);
  store = fw.fwdXxB ? xxVal : (fw.fwdXmB ? mwVal : in.ops.read2Data);
  b = fw.fwdXxB ? xxVal : (fw.fwdXmB ? mwVal : in.ops.aluB);
  if (in.specCtrl.stu) b = in.ops.aluB;
  r.aluOut = aluResult(a, b, in.aluCtrl);
  f = aluStatus(a, b, in.aluCtrl, r.aluOut);
  case (in.flowCtrl.brControl)
    `BR_EQZ: brSel = f.zf;
    `BR_NEZ: brSel = !f.zf;
    `BR_LTZ: brSel = f.sf;
    `BR_GEZ: brSel = !f.sf;
    default: brSel = 1'b0;
  endcase
  offset = in.flowCtrl.immSrc ? in.ops.imm8 : in.ops.imm11;
  r.valid = in.valid;
  r.halt = in.valid & in.halt;
  r.specOps = specialResult(a, in.ops.imm8, in.specCtrl, f);
  r.outData = in.specCtrl.stu ? store : b;
  if (in.flowCtrl.aluJump) r.nextPc = r.aluOut;
  else if (brSel || in.flowCtrl.jump) r.nextPc = in.ops.pc + offset;
  else r.nextPc = in.ops.pc;
  r.flush = in.valid & (in.flowCtrl.aluJump | brSel | in.flowCtrl.jump);
  return r;
endfunction

`endif

/* test/execute_tb.sv */
`include "execute_macros.svh"

module execute_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import execute_pkg::*;

  `include "execute_model.svh"

  localparam int ACCEPT_LIMIT = 16;
  localparam int STALL_CYCLES = 4;
  localparam int CHECK_W = $bits(xmReg_t);

  typedef struct packed {
    exIn_t     in;
    xmBypass_t xm;
    mwBypass_t mw;
    logic      stall;
    xmReg_t    exp;
  } vector_t;

  logic      clk = 1'b0;
  logic      rstN = 1'b0;
  logic      stall = 1'b0;
  exIn_t     exIn = '0;
  xmBypass_t xmBypass = '0;
  mwBypass_t mwBypass = '0;
  xmReg_t    xmOut;

  logic [31:0] rngState = 32'h221c_5dcf;
  vector_t     vectors[$];
  logic        timedOut = 1'b0;
  int          checks = 0;
  int          testErrors = 0;
  int          totalChecks = 0;
  int          totalErrors = 0;
  int          testsRun = 0;
  int          testsFailed = 0;

  execute_stage dut_i (
    .clk      (clk),
    .rstN     (rstN),
    .stall    (stall),
    .exIn     (exIn),
    .xmBypass (xmBypass),
    .mwBypass (mwBypass),
    .xmOut    (xmOut)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [`DATA_W-1:0] randomWord();
    rngState = xorshift32(rngState);
    return rngState[31:16];
  endfunction

  // valid instruction with random operands and every control off
  function automatic exIn_t newInstr();
    exIn_t in;
    in = '0;
    in.valid = 1'b1;
    in.ops = {randomWord(), randomWord(), randomWord(), randomWord(), randomWord(), randomWord()};
    return in;
  endfunction

  task automatic checkValue(input logic [CHECK_W-1:0] got, input logic [CHECK_W-1:0] want,
                            input string what);
    checks++;
    if (got !== want) begin
      testErrors++;
      $display("error at %0d ns: %s is %h, expected %h", $time, what, got, want);
    end
  endtask

  task automatic pushVector(input exIn_t in, input logic stl);
    vector_t v;
    v.in = in;
    v.xm = {randomWord(), randomWord(), randomWord()};
    v.mw = {randomWord(), randomWord(), randomWord(), randomWord()};
    v.stall = stl;
    v.exp = expectedXm(v.in, v.xm, v.mw);
    vectors.push_back(v);
  endtask

  // starts and ends at a falling edge
  task automatic applyVector(input vector_t v);
    xmReg_t held;
    int     cycles;
    logic   accepted;
    held = xmOut;
    cycles = 0;
    accepted = 1'b0;
    @(posedge clk);
    exIn     <= v.in;
    xmBypass <= v.xm;
    mwBypass <= v.mw;
    stall    <= v.stall;
    while (!accepted && cycles < ACCEPT_LIMIT) begin
      @(posedge clk);
      cycles++;
      if (!stall) begin
        accepted = 1'b1;
      end else begin
        if (cycles >= STALL_CYCLES) begin
          stall <= 1'b0;
        end
        @(negedge clk);
        checkValue(xmOut, held, "xmOut under stall");
      end
    end
    if (!accepted) begin
      testErrors++;
      timedOut = 1'b1;
      $display("timeout: instruction was not accepted within %0d cycles", ACCEPT_LIMIT);
    end else begin
      @(negedge clk);
      checkValue(xmOut, v.exp, "xmOut");
    end
  endtask

  task automatic reportTest(input string name);
    string verdict;
    if (testErrors == 0) verdict = "ok";
    else verdict = "failed";
    testsRun++;
    totalChecks += checks;
    totalErrors += testErrors;
    if (testErrors != 0) testsFailed++;
    $display("test %-14s %s, %0d checks, %0d errors", name, verdict, checks, testErrors);
    checks = 0;
    testErrors = 0;
  endtask

  task automatic runVectors(input string name);
    foreach (vectors[i]) begin
      if (!timedOut) begin
        applyVector(vectors[i]);
      end
    end
    reportTest(name);
    vectors.delete();
  endtask

  task automatic resetDut();
    xmReg_t want;
    for (int i = 0; i < 16; i++) begin
      @(posedge clk);
    end
    rstN <= 1'b1;
    @(negedge clk);
    // the payload has no reset value so only the control bits are compared
    want = xmOut;
    want.valid = 1'b0;
    want.flush = 1'b0;
    want.halt = 1'b0;
    checkValue(xmOut, want, "xmOut control bits after reset");
    reportTest("reset");
  endtask

  task automatic aluVectors();
    exIn_t in;
    for (int op = 0; op < 8; op++) begin
      for (int n = 0; n < 3; n++) begin
        in = newInstr();
        in.aluCtrl.aluOp = op[2:0];
        pushVector(in, 1'b0);
      end
    end
    // subtract is ~A + B + 1
    for (int n = 0; n < 3; n++) begin
      in = newInstr();
      in.aluCtrl = {`ALU_ADD, 3'b101};
      pushVector(in, 1'b0);
    end
    in = newInstr();
    in.aluCtrl = {`ALU_AND, 3'b010};
    pushVector(in, 1'b0);
  endtask

  task automatic specialVectors();
    exIn_t in;
    for (int sc = 0; sc < 4; sc++) begin
      for (int n = 0; n < 3; n++) begin
        in = newInstr();
        in.aluCtrl = {`ALU_ADD, 3'b101};
        in.specCtrl.setIf = 1'b1;
        in.specCtrl.setControl = sc[1:0];
        if (n == 0) in.ops.aluB = in.ops.aluA;
        pushVector(in, 1'b0);
      end
    end
    in = newInstr();
    in.specCtrl.lbi = 1'b1;
    pushVector(in, 1'b0);
    in = newInstr();
    in.specCtrl.btr = 1'b1;
    pushVector(in, 1'b0);
    // no special control selects slbi
    in = newInstr();
    pushVector(in, 1'b0);
  endtask

  // btr puts the reversed A operand on specOps so A is visible
  task automatic forwardVectors();
    exIn_t in;
    for (int s = 0; s < 4; s++) begin
      if (s != 2) begin
        in = newInstr();
        in.fwdCtrl = {4'b1100, s[1:0], 2'd0};
        in.specCtrl.btr = 1'b1;
        pushVector(in, 1'b0);
      end
      in = newInstr();
      in.fwdCtrl = {4'b0011, 2'd0, s[1:0]};
      in.specCtrl.btr = 1'b1;
      pushVector(in, 1'b0);
      in = newInstr();
      in.fwdCtrl = {4'b1111, `XX_ALU, s[1:0]};
      in.specCtrl.btr = 1'b1;
      pushVector(in, 1'b0);
      in = newInstr();
      in.fwdCtrl = {4'b0101, (s == 2) ? `XX_PCINC : s[1:0], s[1:0]};
      in.specCtrl.stu = 1'b1;
      pushVector(in, 1'b0);
      in = newInstr();
      in.fwdCtrl = {4'b0001, 2'd0, s[1:0]};
      in.specCtrl.stu = 1'b1;
      pushVector(in, 1'b0);
    end
  endtask

  task automatic flowVectors();
    exIn_t in;
    for (int br = 0; br < 5; br++) begin
      for (int n = 0; n < 3; n++) begin
        in = newInstr();
        in.ops.aluB = '0;
        in.flowCtrl.brControl = br[2:0];
        if (n == 0) in.ops.aluA = '0;
        else in.ops.aluA[`DATA_W-1] = (n == 1);
        pushVector(in, 1'b0);
      end
    end
    for (int s = 0; s < 2; s++) begin
      in = newInstr();
      in.flowCtrl.jump = 1'b1;
      in.flowCtrl.immSrc = s[0];
      pushVector(in, 1'b0);
    end
    in = newInstr();
    in.flowCtrl.aluJump = 1'b1;
    pushVector(in, 1'b0);
  endtask

  task automatic pipelineVectors();
    exIn_t in;
    in = newInstr();
    in.halt = 1'b1;
    pushVector(in, 1'b0);
    // bubble carrying stale controls
    in = newInstr();
    in.valid = 1'b0;
    in.halt = 1'b1;
    in.flowCtrl.jump = 1'b1;
    pushVector(in, 1'b0);
    in = newInstr();
    in.flowCtrl.jump = 1'b1;
    pushVector(in, 1'b0);
    in = newInstr();
    in.flowCtrl.aluJump = 1'b1;
    pushVector(in, 1'b1);
    in = newInstr();
    pushVector(in, 1'b0);
  endtask

  initial begin
    resetDut();
    aluVectors();
    runVectors("alu ops");
    specialVectors();
    runVectors("special ops");
    forwardVectors();
    runVectors("forwarding");
    flowVectors();
    runVectors("change of flow");
    pipelineVectors();
    runVectors("pipeline");
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             testsRun, testsFailed, totalChecks, totalErrors);
    if (totalErrors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+source
+incdir+test
source/execute_pkg.sv
source/forward_unit.sv
source/alu.sv
source/special_ops.sv
source/execute.sv
source/execute_stage.sv
test/execute_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = execute_tb
FILELIST = build.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "SOME TESTS FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
